// ==== Bender.yml ====
package:
  name: seq_ddr3

sources:
  - design/seq_pkg.sv
  - design/seq_cfg_if.sv
  - design/seq_apb_regs.sv
  - design/seq_cmd_mem.sv
  - design/seq_pause_timer.sv
  - design/seq_wbuf_delay.sv
  - design/seq_fsm.sv
  - design/seq_top.sv
  - target: simulation
    files:
      - verification/seq_tb.sv

// ==== design/seq_apb_regs.sv ====
`timescale 1ns/1ps

module seq_apb_regs (
    input  logic                            mclk,
    input  logic                            rst,
    input  logic                            psel_i,
    input  logic                            penable_i,
    input  logic                            pwrite_i,
    input  logic [seq_pkg::APB_AW-1:0]      paddr_i,
    input  logic [seq_pkg::APB_DW-1:0]      pwdata_i,
    output logic [seq_pkg::APB_DW-1:0]      prdata_o,
    output logic                            pready_o,
    input  logic                            busy_i,      // sequencer running
    seq_cfg_if.src                          cfg,
    output logic                            mem_we_o,
    output logic [seq_pkg::CMD_ADDR_W-1:0]  mem_waddr_o,
    output logic [seq_pkg::APB_DW-1:0]      mem_wdata_o
);

    logic wr_acc;   // write in the access phase
    logic in_mem;   // address inside command memory window

    assign pready_o = 1'b1;   // no wait states
    assign wr_acc   = psel_i && penable_i && pwrite_i;
    assign in_mem   = paddr_i[seq_pkg::APB_AW-1:seq_pkg::MEM_LSB] ==
                      seq_pkg::MEM_BASE[seq_pkg::APB_AW-1:seq_pkg::MEM_LSB];

    // memory writes go straight through in the access cycle
    assign mem_we_o    = wr_acc && in_mem;
    assign mem_waddr_o = paddr_i[seq_pkg::MEM_LSB-1:2];   // word index
    assign mem_wdata_o = pwdata_i;

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            cfg.ddr_rst    <= seq_pkg::CTRL_RST[seq_pkg::CTRL_SDRST];
            cfg.cke_en     <= seq_pkg::CTRL_RST[seq_pkg::CTRL_CKE];
            cfg.cmda_en    <= seq_pkg::CTRL_RST[seq_pkg::CTRL_CMDA];
            cfg.wbuf_delay <= seq_pkg::DFLT_WBUF_DELAY;
        end else if (wr_acc) begin
            if (paddr_i == seq_pkg::REG_CTRL) begin
                cfg.ddr_rst <= pwdata_i[seq_pkg::CTRL_SDRST];
                cfg.cke_en  <= pwdata_i[seq_pkg::CTRL_CKE];
                cfg.cmda_en <= pwdata_i[seq_pkg::CTRL_CMDA];
            end
            if (paddr_i == seq_pkg::REG_WBUF_DLY) begin
                cfg.wbuf_delay <= pwdata_i[seq_pkg::DLY_W-1:0];
            end
        end
    end

    // readback where the memory window and holes give 0
    always_comb begin
        prdata_o = '0;
        case (paddr_i)
            seq_pkg::REG_CTRL: begin
                prdata_o[seq_pkg::CTRL_SDRST] = cfg.ddr_rst;
                prdata_o[seq_pkg::CTRL_CKE]   = cfg.cke_en;
                prdata_o[seq_pkg::CTRL_CMDA]  = cfg.cmda_en;
            end
            seq_pkg::REG_WBUF_DLY: prdata_o[seq_pkg::DLY_W-1:0] = cfg.wbuf_delay;
            seq_pkg::REG_STATUS:   prdata_o[seq_pkg::STAT_BUSY] = busy_i;
            default: ;
        endcase
    end

endmodule

// ==== design/seq_cfg_if.sv ====
`timescale 1ns/1ps

interface seq_cfg_if;
    logic                      ddr_rst;     // ddr3 reset that also aborts the sequencer
    logic                      cke_en;
    logic                      cmda_en;     // 0 forces nop on the pins
    logic [seq_pkg::DLY_W-1:0] wbuf_delay;  // extra write enable delay

    modport src (
        output ddr_rst, cke_en, cmda_en, wbuf_delay
    );

    modport fsm (
        input ddr_rst, cmda_en
    );

    modport dly (
        input wbuf_delay
    );
endinterface

// ==== design/seq_cmd_mem.sv ====
`timescale 1ns/1ps

module seq_cmd_mem (
    input  logic                            mclk,
    input  logic                            we_i,      // apb side
    input  logic [seq_pkg::CMD_ADDR_W-1:0]  waddr_i,
    input  logic [seq_pkg::APB_DW-1:0]      wdata_i,
    input  logic                            ren_i,     // sequencer side
    input  logic [seq_pkg::CMD_ADDR_W-1:0]  raddr_i,
    output seq_pkg::cmd_word_u              rdata_o    // one cycle after ren_i
);

    logic [seq_pkg::APB_DW-1:0] mem [seq_pkg::CMD_DEPTH];

    always_ff @(posedge mclk) begin
        if (we_i) begin
            mem[waddr_i] <= wdata_i;
        end
    end

    // registered read that holds its output while ren_i is low
    always_ff @(posedge mclk) begin
        if (ren_i) begin
            rdata_o <= mem[raddr_i];
        end
    end

endmodule

// ==== design/seq_fsm.sv ====
`timescale 1ns/1ps

module seq_fsm (
    input  logic                            mclk,
    input  logic                            rst,
    input  logic                            run_seq_i,     // start pulse
    input  logic [seq_pkg::CMD_ADDR_W-1:0]  run_addr_i,
    input  logic [seq_pkg::CHN_W-1:0]       run_chn_i,
    seq_cfg_if.fsm                          cfg,
    output logic                            mem_ren_o,
    output logic [seq_pkg::CMD_ADDR_W-1:0]  mem_raddr_o,
    input  seq_pkg::cmd_word_u              mem_rdata_i,
    output logic                            timer_load_o,
    output logic [seq_pkg::PAUSE_W-1:0]     timer_len_o,
    input  logic                            timer_busy_i,
    output logic                            busy_o,
    output logic                            done_o,
    output logic                            sd_ras_n_o,
    output logic                            sd_cas_n_o,
    output logic                            sd_we_n_o,
    output logic                            sd_odt_o,
    output logic [seq_pkg::BA_W-1:0]        sd_ba_o,
    output logic [seq_pkg::SDA_W-1:0]       sd_a_o,
    output logic                            buf_rd_o,
    output logic                            buf_wr_o,
    output logic [seq_pkg::CHN_W-1:0]       chn_o          // latched run channel
);

    logic [1:0]                  state;
    logic                        rvalid;        // mem_rdata_i is a fresh word
    logic                        issue;         // word goes to the pins this cycle
    logic                        is_nop;
    logic                        pause_start;
    logic [seq_pkg::PAUSE_W-1:0] plen;

    assign issue  = (state == seq_pkg::ST_ISSUE) && rvalid && !cfg.ddr_rst;
    assign is_nop = mem_rdata_i.cmd.ras_n && mem_rdata_i.cmd.cas_n && mem_rdata_i.cmd.we_n;
    assign plen   = mem_rdata_i.nop.pause;
    assign pause_start = issue && is_nop && !mem_rdata_i.cmd.done && (plen != '0);

    // issue cycle is the first pause cycle and the timer covers the rest
    assign timer_load_o = pause_start || cfg.ddr_rst;   // ddr reset clears a pending pause
    assign timer_len_o  = pause_start ? plen - 1'b1 : '0;

    assign mem_ren_o = ((state == seq_pkg::ST_FETCH) || (state == seq_pkg::ST_ISSUE)) &&
                       !pause_start && !timer_busy_i;   // stall fetch during pause
    assign busy_o    = (state != seq_pkg::ST_IDLE);

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            state       <= seq_pkg::ST_IDLE;
            rvalid      <= 1'b0;
            done_o      <= 1'b0;
            mem_raddr_o <= '0;
            chn_o       <= '0;
        end else begin
            done_o <= 1'b0;
            rvalid <= mem_ren_o && !cfg.ddr_rst;
            if (mem_ren_o) begin
                mem_raddr_o <= mem_raddr_o + 1'b1;   // prefetch next word
            end
            if (cfg.ddr_rst) begin
                state <= seq_pkg::ST_IDLE;           // abort without a done pulse
            end else begin
                case (state)
                    seq_pkg::ST_IDLE: begin
                        if (run_seq_i) begin
                            state       <= seq_pkg::ST_FETCH;
                            mem_raddr_o <= run_addr_i;
                            chn_o       <= run_chn_i;
                        end
                    end
                    seq_pkg::ST_FETCH: state <= seq_pkg::ST_ISSUE;
                    seq_pkg::ST_ISSUE: begin
                        if (issue && mem_rdata_i.cmd.done) begin
                            state <= seq_pkg::ST_FINISH;   // prefetched word dropped
                        end
                    end
                    default: begin
                        state  <= seq_pkg::ST_IDLE;
                        done_o <= 1'b1;
                    end
                endcase
            end
        end
    end

    // command pins show nop with zero address outside issue cycles
    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            sd_ras_n_o <= 1'b1;
            sd_cas_n_o <= 1'b1;
            sd_we_n_o  <= 1'b1;
            sd_odt_o   <= 1'b0;
            sd_ba_o    <= '0;
            sd_a_o     <= '0;
            buf_rd_o   <= 1'b0;
            buf_wr_o   <= 1'b0;
        end else begin
            buf_rd_o <= issue && mem_rdata_i.cmd.buf_rd;   // not gated by cmda_en
            buf_wr_o <= issue && mem_rdata_i.cmd.buf_wr;
            if (issue && cfg.cmda_en) begin
                sd_ras_n_o <= mem_rdata_i.cmd.ras_n;
                sd_cas_n_o <= mem_rdata_i.cmd.cas_n;
                sd_we_n_o  <= mem_rdata_i.cmd.we_n;
                sd_odt_o   <= mem_rdata_i.cmd.odt;
                sd_ba_o    <= mem_rdata_i.cmd.ba;
                sd_a_o     <= mem_rdata_i.cmd.sda;
            end else begin
                sd_ras_n_o <= 1'b1;
                sd_cas_n_o <= 1'b1;
                sd_we_n_o  <= 1'b1;
                sd_odt_o   <= 1'b0;
                sd_ba_o    <= '0;
                sd_a_o     <= '0;
            end
        end
    end

endmodule

// ==== design/seq_pause_timer.sv ====
`timescale 1ns/1ps

module seq_pause_timer (
    input  logic                         mclk,
    input  logic                         rst,
    input  logic                         load_i,   // start a pause
    input  logic [seq_pkg::PAUSE_W-1:0]  len_i,    // cycles to hold
    output logic                         busy_o
);

    logic [seq_pkg::PAUSE_W-1:0] cnt;   // remaining pause cycles

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            cnt <= '0;
        end else if (load_i) begin
            cnt <= len_i;
        end else if (cnt != '0) begin
            cnt <= cnt - 1'b1;
        end
    end

    assign busy_o = (cnt != '0);

endmodule

// ==== design/seq_pkg.sv ====
package seq_pkg;

    localparam int CMD_ADDR_W = 8;                // command memory word address
    localparam int CMD_DEPTH  = 256;              // command words
    localparam int PAUSE_W    = 10;               // nop pause length
    localparam int SDA_W      = 15;               // ddr3 address pins
    localparam int BA_W       = 3;                // ddr3 bank pins
    localparam int CHN_W      = 4;                // buffer channel number
    localparam int DLY_W      = 4;                // write buffer delay
    localparam int APB_AW     = 12;
    localparam int APB_DW     = 32;
    localparam int SPARE_W    = 7;                // unused low bits of a command word
    localparam int MEM_LSB    = CMD_ADDR_W + 2;   // first paddr bit above the memory window

    // register map
    localparam logic [APB_AW-1:0] REG_CTRL     = 12'h000;
    localparam logic [APB_AW-1:0] REG_WBUF_DLY = 12'h004;
    localparam logic [APB_AW-1:0] REG_STATUS   = 12'h008;   // read only
    localparam logic [APB_AW-1:0] MEM_BASE     = 12'h400;   // command memory window

    localparam int CTRL_SDRST = 0;                // ddr reset active
    localparam int CTRL_CKE   = 1;                // cke enable
    localparam int CTRL_CMDA  = 2;                // command/address pins enable
    localparam int STAT_BUSY  = 0;

    localparam logic [2:0]       CTRL_RST        = 3'b001;  // ddr held in reset
    localparam logic [DLY_W-1:0] DFLT_WBUF_DELAY = 4'd6;

    // sequencer states
    localparam logic [1:0] ST_IDLE   = 2'd0;
    localparam logic [1:0] ST_FETCH  = 2'd1;
    localparam logic [1:0] ST_ISSUE  = 2'd2;
    localparam logic [1:0] ST_FINISH = 2'd3;

    typedef struct packed {
        logic               done;     // last word of the sequence
        logic               buf_wr;   // delayed write buffer enable
        logic               buf_rd;   // aligned read buffer enable
        logic               odt;
        logic               ras_n;
        logic               cas_n;
        logic               we_n;
        logic [BA_W-1:0]    ba;
        logic [SDA_W-1:0]   sda;
        logic [SPARE_W-1:0] spare;
    } cmd_view_t;

    // nop view where the address field holds the pause length
    typedef struct packed {
        logic [6:0]             ctl;      // same bits as the command view
        logic [BA_W-1:0]        ba_rsvd;
        logic [SDA_W-PAUSE_W-1:0] a_rsvd;
        logic [PAUSE_W-1:0]     pause;    // extra nop cycles
        logic [SPARE_W-1:0]     spare;
    } pause_view_t;

    typedef union packed {
        cmd_view_t   cmd;
        pause_view_t nop;
    } cmd_word_u;

endpackage

// ==== design/seq_top.sv ====
`timescale 1ns/1ps

module seq_top (
    input  logic                            mclk,
    input  logic                            rst,
    input  logic                            psel_i,
    input  logic                            penable_i,
    input  logic                            pwrite_i,
    input  logic [seq_pkg::APB_AW-1:0]      paddr_i,
    input  logic [seq_pkg::APB_DW-1:0]      pwdata_i,
    output logic [seq_pkg::APB_DW-1:0]      prdata_o,
    output logic                            pready_o,
    input  logic                            run_seq_i,
    input  logic [seq_pkg::CMD_ADDR_W-1:0]  run_addr_i,
    input  logic [seq_pkg::CHN_W-1:0]       run_chn_i,
    output logic                            run_busy_o,
    output logic                            run_done_o,
    output logic                            sd_rst_n_o,
    output logic                            cke_o,
    output logic                            sd_ras_n_o,
    output logic                            sd_cas_n_o,
    output logic                            sd_we_n_o,
    output logic                            sd_odt_o,
    output logic [seq_pkg::BA_W-1:0]        sd_ba_o,
    output logic [seq_pkg::SDA_W-1:0]       sd_a_o,
    output logic                            ext_buf_rd_o,
    output logic                            ext_buf_wr_o,
    output logic [seq_pkg::CHN_W-1:0]       ext_buf_wchn_o
);

    logic                           mem_we;
    logic [seq_pkg::CMD_ADDR_W-1:0] mem_waddr;
    logic [seq_pkg::APB_DW-1:0]     mem_wdata;
    logic                           mem_ren;
    logic [seq_pkg::CMD_ADDR_W-1:0] mem_raddr;
    seq_pkg::cmd_word_u             mem_rdata;
    logic                           timer_load;
    logic [seq_pkg::PAUSE_W-1:0]    timer_len;
    logic                           timer_busy;
    logic                           buf_wr;      // undelayed write enable
    logic [seq_pkg::CHN_W-1:0]      run_chn;     // latched channel

    seq_cfg_if cfg_if ();

    assign sd_rst_n_o = ~cfg_if.ddr_rst;   // pin is active low
    assign cke_o      = cfg_if.cke_en;

    seq_apb_regs u_regs (
        .mclk        (mclk),
        .rst         (rst),
        .psel_i      (psel_i),
        .penable_i   (penable_i),
        .pwrite_i    (pwrite_i),
        .paddr_i     (paddr_i),
        .pwdata_i    (pwdata_i),
        .prdata_o    (prdata_o),
        .pready_o    (pready_o),
        .busy_i      (run_busy_o),
        .cfg         (cfg_if.src),
        .mem_we_o    (mem_we),
        .mem_waddr_o (mem_waddr),
        .mem_wdata_o (mem_wdata)
    );

    seq_cmd_mem u_mem (
        .mclk    (mclk),
        .we_i    (mem_we),
        .waddr_i (mem_waddr),
        .wdata_i (mem_wdata),
        .ren_i   (mem_ren),
        .raddr_i (mem_raddr),
        .rdata_o (mem_rdata)
    );

    seq_fsm u_fsm (
        .mclk         (mclk),
        .rst          (rst),
        .run_seq_i    (run_seq_i),
        .run_addr_i   (run_addr_i),
        .run_chn_i    (run_chn_i),
        .cfg          (cfg_if.fsm),
        .mem_ren_o    (mem_ren),
        .mem_raddr_o  (mem_raddr),
        .mem_rdata_i  (mem_rdata),
        .timer_load_o (timer_load),
        .timer_len_o  (timer_len),
        .timer_busy_i (timer_busy),
        .busy_o       (run_busy_o),
        .done_o       (run_done_o),
        .sd_ras_n_o   (sd_ras_n_o),
        .sd_cas_n_o   (sd_cas_n_o),
        .sd_we_n_o    (sd_we_n_o),
        .sd_odt_o     (sd_odt_o),
        .sd_ba_o      (sd_ba_o),
        .sd_a_o       (sd_a_o),
        .buf_rd_o     (ext_buf_rd_o),
        .buf_wr_o     (buf_wr),
        .chn_o        (run_chn)
    );

    seq_pause_timer u_timer (
        .mclk   (mclk),
        .rst    (rst),
        .load_i (timer_load),
        .len_i  (timer_len),
        .busy_o (timer_busy)
    );

    seq_wbuf_delay u_wdly (
        .mclk  (mclk),
        .rst   (rst),
        .wr_i  (buf_wr),
        .chn_i (run_chn),
        .cfg   (cfg_if.dly),
        .wr_o  (ext_buf_wr_o),
        .chn_o (ext_buf_wchn_o)
    );

endmodule

// ==== design/seq_wbuf_delay.sv ====
`timescale 1ns/1ps

module seq_wbuf_delay (
    input  logic                       mclk,
    input  logic                       rst,
    input  logic                       wr_i,     // buf_wr as issued
    input  logic [seq_pkg::CHN_W-1:0]  chn_i,
    seq_cfg_if.dly                     cfg,
    output logic                       wr_o,     // wbuf_delay + 1 cycles later
    output logic [seq_pkg::CHN_W-1:0]  chn_o
);

    logic [2**seq_pkg::DLY_W-1:0]                        wr_sr;    // enable stages
    logic [2**seq_pkg::DLY_W-1:0][seq_pkg::CHN_W-1:0]    chn_sr;   // channel stages

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            wr_sr <= '0;
        end else begin
            wr_sr <= {wr_sr[2**seq_pkg::DLY_W-2:0], wr_i};
        end
    end

    // channel shifts alongside the enable
    always_ff @(posedge mclk) begin
        chn_sr <= {chn_sr[2**seq_pkg::DLY_W-2:0], chn_i};
    end

    // stage 0 already adds one cycle
    assign wr_o  = wr_sr[cfg.wbuf_delay];
    assign chn_o = chn_sr[cfg.wbuf_delay];

endmodule

// ==== verification/seq_tb.sv ====
`timescale 1ns/1ps

module seq_tb;

    typedef struct packed {
        logic        busy;
        logic        done;
        logic        ras_n;
        logic        cas_n;
        logic        we_n;
        logic        odt;
        logic [2:0]  ba;
        logic [14:0] a;
        logic        buf_rd;
        logic        buf_wr;      // undelayed
    } pins_t;

    logic                           mclk;
    logic                           rst;
    logic                           psel_i;
    logic                           penable_i;
    logic                           pwrite_i;
    logic                           pready_o;
    logic [seq_pkg::APB_AW-1:0]     paddr_i;
    logic [seq_pkg::APB_DW-1:0]     pwdata_i;
    logic [seq_pkg::APB_DW-1:0]     prdata_o;
    logic                           run_seq_i;
    logic                           run_busy_o;
    logic                           run_done_o;
    logic [seq_pkg::CMD_ADDR_W-1:0] run_addr_i;
    logic [seq_pkg::CHN_W-1:0]      run_chn_i;
    logic [seq_pkg::CHN_W-1:0]      ext_buf_wchn_o;
    logic                           sd_rst_n_o;
    logic                           cke_o;
    logic                           sd_ras_n_o;
    logic                           sd_cas_n_o;
    logic                           sd_we_n_o;
    logic                           sd_odt_o;
    logic [seq_pkg::BA_W-1:0]       sd_ba_o;
    logic [seq_pkg::SDA_W-1:0]      sd_a_o;
    logic                           ext_buf_rd_o;
    logic                           ext_buf_wr_o;

    logic [31:0] mem_img [256];   // copy of what was written to the command memory
    pins_t       exp_q [$];       // expected pins from the first issue cycle on
    logic        chk_on;
    int          chk_idx;
    int          chk_dly;         // wbuf delay in effect
    logic [3:0]  chk_chn;
    int          errors;
    int          timeouts;

    seq_top DUT (.*);

    always #10 mclk = ~mclk;   // 20 ns

    function automatic pins_t idle_pins();
        pins_t p;
        p       = '0;
        p.ras_n = 1'b1;
        p.cas_n = 1'b1;
        p.we_n  = 1'b1;
        return p;
    endfunction

    // one entry per cycle from the first issue cycle up to the done pulse
    function automatic int build_trace(input logic [31:0] img [256], input logic [7:0] start,
                                       input logic cmda);
        logic [7:0]  addr;
        logic [31:0] w;
        pins_t       p;
        int          n;
        int          k;
        bit          fin;
        addr = start;
        fin  = 1'b0;
        exp_q.delete();
        for (n = 0; n < 256 && !fin; n++) begin
            w        = img[addr];
            addr     = addr + 1'b1;
            p        = idle_pins();
            p.busy   = 1'b1;
            p.buf_rd = w[29];     // enables pass even with cmda_en low
            p.buf_wr = w[30];
            if (cmda) begin
                p.odt   = w[28];
                p.ras_n = w[27];
                p.cas_n = w[26];
                p.we_n  = w[25];
                p.ba    = w[24:22];
                p.a     = w[21:7];
            end
            exp_q.push_back(p);
            p = idle_pins();
            if (w[31]) begin
                p.done = 1'b1;    // busy already low here
                exp_q.push_back(p);
                fin = 1'b1;
            end else if (w[27:25] == 3'b111) begin
                p.busy = 1'b1;
                for (k = 0; k < int'(w[16:7]); k++) begin
                    exp_q.push_back(p);   // extra nop cycles
                end
            end
        end
        return exp_q.size();
    endfunction

    task automatic check_val(input string name, input logic [31:0] act, input logic [31:0] exp);
        assert (act === exp) else begin
            errors++;
            $display("FAILED t=%0t %s: expected %0h, got %0h", $time, name, exp, act);
        end
    endtask

    task automatic apb_xfer(input logic wr, input logic [11:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata);
        int n;
        @(negedge mclk);
        psel_i    = 1'b1;   // setup
        penable_i = 1'b0;
        pwrite_i  = wr;
        paddr_i   = addr;
        pwdata_i  = wdata;
        @(negedge mclk);
        penable_i = 1'b1;   // access
        n = 0;
        while (pready_o !== 1'b1 && n < 16) begin
            @(negedge mclk);
            n++;
        end
        if (n == 16) begin
            timeouts++;
            $display("timeout: APB slave never raised pready at t=%0t", $time);
        end
        rdata = prdata_o;
        @(negedge mclk);
        psel_i    = 1'b0;
        penable_i = 1'b0;
        pwrite_i  = 1'b0;
    endtask

    task automatic apb_write(input logic [11:0] addr, input logic [31:0] data);
        logic [31:0] unused;
        apb_xfer(1'b1, addr, data, unused);
    endtask

    task automatic apb_read_check(input logic [11:0] addr, input logic [31:0] exp,
                                  input string name);
        logic [31:0] rd;
        apb_xfer(1'b0, addr, '0, rd);
        check_val(name, rd, exp);
    endtask

    task automatic set_delay(input int d);
        apb_write(seq_pkg::REG_WBUF_DLY, d);
        chk_dly = d;
    endtask

    task automatic load_seq(input logic [7:0] start, input int len, input int nop_pct);
        logic [31:0] w;
        logic [7:0]  idx;
        int          i;
        for (i = 0; i < len; i++) begin
            w     = $urandom;
            idx   = start + i[7:0];
            w[31] = (i == len - 1);              // done on last word only
            if (($urandom % 100) < nop_pct) begin
                w[27:25] = 3'b111;               // nop with pause 0..5
                w[16:7]  = $urandom % 6;
            end else if (w[27:25] == 3'b111) begin
                w[25] = 1'b0;                    // keep it a real command
            end
            mem_img[idx] = w;
            apb_write(seq_pkg::MEM_BASE + {2'b00, idx, 2'b00}, w);
        end
    endtask

    task automatic pulse_run(input logic [7:0] start, input logic [3:0] chn);
        @(negedge mclk);
        run_seq_i  = 1'b1;
        run_addr_i = start;
        run_chn_i  = chn;
        @(negedge mclk);
        run_seq_i = 1'b0;
    endtask

    task automatic run_check(input logic [7:0] start, input logic [3:0] chn, input logic cmda,
                             input bit poke);
        int n;
        n       = build_trace(mem_img, start, cmda) + 40;
        chk_chn = chn;
        chk_idx = 0;
        pulse_run(start, chn);
        check_val("run_busy_o", run_busy_o, 1'b1);
        @(negedge mclk);
        chk_on <= 1'b1;          // first issue at the next sample
        if (poke) begin
            @(negedge mclk);
            run_seq_i  = 1'b1;   // lands while busy
            run_addr_i = start + 8'd1;
            @(negedge mclk);
            run_seq_i = 1'b0;
        end
        do begin
            @(negedge mclk);
            n--;
        end while (chk_on && n > 0);
        if (chk_on) begin
            timeouts++;
            $display("timeout: sequence at %0h never finished its trace", start);
            chk_on = 1'b0;
        end
    endtask

    // sampled mid-cycle away from the rising edge
    always @(negedge mclk) begin : compare
        pins_t e;
        int    k;
        logic  wr_exp;
        if (chk_on) begin
            e      = (chk_idx < exp_q.size()) ? exp_q[chk_idx] : idle_pins();
            k      = chk_idx - chk_dly - 1;   // issue cycle behind the delayed enable
            wr_exp = (k >= 0 && k < exp_q.size()) ? exp_q[k].buf_wr : 1'b0;
            check_val("run_busy_o", run_busy_o, e.busy);
            check_val("run_done_o", run_done_o, e.done);
            check_val("sd_ras_n_o", sd_ras_n_o, e.ras_n);
            check_val("sd_cas_n_o", sd_cas_n_o, e.cas_n);
            check_val("sd_we_n_o", sd_we_n_o, e.we_n);
            check_val("sd_odt_o", sd_odt_o, e.odt);
            check_val("sd_ba_o", sd_ba_o, e.ba);
            check_val("sd_a_o", sd_a_o, e.a);
            check_val("ext_buf_rd_o", ext_buf_rd_o, e.buf_rd);
            check_val("ext_buf_wr_o", ext_buf_wr_o, wr_exp);
            if (wr_exp) begin
                check_val("ext_buf_wchn_o", ext_buf_wchn_o, chk_chn);
            end
            chk_idx++;
            if (chk_idx >= exp_q.size() + 18) begin
                chk_on = 1'b0;   // delay line drained
            end
        end
    end

    initial begin : stim
        int d;
        mclk       = 1'b0;
        rst        = 1'b1;
        psel_i     = 1'b0;
        penable_i  = 1'b0;
        pwrite_i   = 1'b0;
        paddr_i    = '0;
        pwdata_i   = '0;
        run_seq_i  = 1'b0;
        run_addr_i = '0;
        run_chn_i  = '0;
        chk_on     = 1'b0;
        chk_idx    = 0;
        chk_dly    = 6;
        errors     = 0;
        timeouts   = 0;
        void'($urandom(84));
        repeat (4) @(negedge mclk);
        rst = 1'b0;

        // reset state
        apb_read_check(seq_pkg::REG_CTRL, 32'h1, "ctrl");
        apb_read_check(seq_pkg::REG_WBUF_DLY, 32'h6, "wbuf_dly");
        apb_read_check(seq_pkg::REG_STATUS, 32'h0, "status");
        apb_read_check(seq_pkg::MEM_BASE + 12'h10, 32'h0, "mem window");
        check_val("sd_ras_n_o", sd_ras_n_o, 1'b1);
        check_val("sd_cas_n_o", sd_cas_n_o, 1'b1);
        check_val("sd_we_n_o", sd_we_n_o, 1'b1);
        check_val("sd_rst_n_o", sd_rst_n_o, 1'b0);
        check_val("cke_o", cke_o, 1'b0);
        check_val("run_done_o", run_done_o, 1'b0);
        check_val("ext_buf_rd_o", ext_buf_rd_o, 1'b0);
        check_val("ext_buf_wr_o", ext_buf_wr_o, 1'b0);
        pulse_run(8'h00, 4'h0);   // ddr still in reset
        check_val("run_busy_o", run_busy_o, 1'b0);
        repeat (3) begin
            @(negedge mclk);
            check_val("run_busy_o", run_busy_o, 1'b0);
        end

        apb_write(seq_pkg::REG_CTRL, 32'h6);   // out of reset with cke and cmda on
        check_val("sd_rst_n_o", sd_rst_n_o, 1'b1);
        check_val("cke_o", cke_o, 1'b1);

        load_seq(8'h10, 12, 0);    // plain commands
        run_check(8'h10, 4'h3, 1'b1, 1'b0);
        load_seq(8'h40, 10, 60);   // mostly nops
        run_check(8'h40, 4'h9, 1'b1, 1'b0);
        for (d = 0; d < 16; d += 5) begin
            set_delay(d);
            run_check(8'h10, $urandom % 16, 1'b1, 1'b0);
        end

        apb_write(seq_pkg::REG_CTRL, 32'h2);   // cmda off
        run_check(8'h40, 4'h5, 1'b0, 1'b1);

        // abort in the middle of a long pause
        apb_write(seq_pkg::REG_CTRL, 32'h6);
        apb_write(seq_pkg::MEM_BASE + 12'h300, 32'h0e00_6400);   // word c0 is a nop with pause 200
        apb_write(seq_pkg::MEM_BASE + 12'h304, 32'h8000_0000);   // word c1 is the done word
        pulse_run(8'hc0, 4'h1);
        repeat (6) @(negedge mclk);
        check_val("run_busy_o", run_busy_o, 1'b1);
        apb_write(seq_pkg::REG_CTRL, 32'h7);
        @(negedge mclk);
        check_val("run_busy_o", run_busy_o, 1'b0);
        check_val("run_done_o", run_done_o, 1'b0);
        repeat (3) begin
            @(negedge mclk);
            check_val("run_done_o", run_done_o, 1'b0);
        end
        check_val("sd_rst_n_o", sd_rst_n_o, 1'b0);

        $display("errors: %0d mismatches, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
design/seq_pkg.sv
design/seq_cfg_if.sv
design/seq_apb_regs.sv
design/seq_cmd_mem.sv
design/seq_pause_timer.sv
design/seq_wbuf_delay.sv
design/seq_fsm.sv
design/seq_top.sv
verification/seq_tb.sv
